// File: rate_adapt_pkg.sv
package rate_adapt_pkg;

    localparam int sync_hdr_width = 2;
    localparam int payload_width = 64;

    // Legal 66b sync headers. 00 and 11 are illegal.
    localparam logic [sync_hdr_width-1:0] sync_data = 2'b01;
    localparam logic [sync_hdr_width-1:0] sync_ctrl = 2'b10;

    localparam logic [7:0] block_type_ctrl_only = 8'h1e;   // All eight characters are control.

    localparam logic [6:0] ctrl_idle = 7'h00;
    localparam logic [6:0] ctrl_error = 7'h1e;

    localparam int count_width = 16;

    // One 64-bit payload, read either as data octets or as a control block.
    typedef union packed {
        logic [payload_width/8-1:0][7:0] data;   // Octet 0 is first on the wire.
        struct packed {
            logic [7:0][6:0] chars;
            logic [7:0] block_type;               // Sits in octet 0.
        } ctrl;
    } block_payload_u;

    localparam block_payload_u idle_payload =
        block_payload_u'({{8{ctrl_idle}}, block_type_ctrl_only});

    localparam block_payload_u error_payload =
        block_payload_u'({{8{ctrl_error}}, block_type_ctrl_only});

endpackage

// File: block_check.sv
`timescale 1ns/1ps

module block_check (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       in_valid,
    input  rate_adapt_pkg::block_payload_u             in_payload,
    input  logic [rate_adapt_pkg::sync_hdr_width-1:0]  in_sync,
    output logic                                       in_ready,
    output logic                                       chk_valid,
    output rate_adapt_pkg::block_payload_u             chk_payload,
    output logic [rate_adapt_pkg::sync_hdr_width-1:0]  chk_sync,
    output logic                                       chk_is_idle,
    input  logic                                       chk_ready,
    output logic [rate_adapt_pkg::count_width-1:0]     error_count
);
    import rate_adapt_pkg::*;

    logic in_xfer;
    logic hdr_legal;
    logic chars_idle;
    logic blk_idle;

    // Stage is free when empty or when its block leaves this cycle.
    assign in_ready = !chk_valid || chk_ready;
    assign in_xfer = in_valid && in_ready;
    assign hdr_legal = (in_sync == sync_data) || (in_sync == sync_ctrl);

    always_comb begin
        chars_idle = 1'b1;
        for (int i = 0; i < 8; i++) begin
            if (in_payload.ctrl.chars[i] != ctrl_idle) begin
                chars_idle = 1'b0;
            end
        end
    end

    assign blk_idle = (in_sync == sync_ctrl) &&
                      (in_payload.data[0] == block_type_ctrl_only) && chars_idle;   // Type octet.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            chk_valid <= 1'b0;
            error_count <= '0;
        end else begin
            if (in_xfer) begin
                chk_valid <= 1'b1;
            end else if (chk_ready) begin
                chk_valid <= 1'b0;
            end
            if (in_xfer && !hdr_legal && error_count != '1) begin
                error_count <= error_count + 1'b1;   // Saturates.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            chk_payload <= hdr_legal ? in_payload : error_payload;
            chk_sync <= hdr_legal ? in_sync : sync_ctrl;
            chk_is_idle <= blk_idle;
        end
    end

endmodule

// File: idle_deleter.sv
`timescale 1ns/1ps

module idle_deleter #(
    parameter int addr_width = 4,
    parameter int drop_level = 12
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       chk_valid,
    input  rate_adapt_pkg::block_payload_u             chk_payload,
    input  logic [rate_adapt_pkg::sync_hdr_width-1:0]  chk_sync,
    input  logic                                       chk_is_idle,
    output logic                                       chk_ready,
    output logic                                       wr,
    output rate_adapt_pkg::block_payload_u             wr_payload,
    output logic [rate_adapt_pkg::sync_hdr_width-1:0]  wr_sync,
    input  logic                                       full,
    input  logic [addr_width:0]                        space,
    output logic [rate_adapt_pkg::count_width-1:0]     delete_count
);
    localparam logic [addr_width:0] depth = {1'b1, {addr_width{1'b0}}};
    localparam logic [addr_width:0] drop_fill = (addr_width+1)'(drop_level);

    logic [addr_width:0] fill;
    logic chk_xfer;
    logic drop;

    assign fill = depth - space;

    assign chk_ready = !full;
    assign chk_xfer = chk_valid && chk_ready;

    // An idle taken near the top of the buffer is accepted and thrown away.
    assign drop = chk_xfer && chk_is_idle && (fill >= drop_fill);

    assign wr = chk_xfer && !drop;
    assign wr_payload = chk_payload;
    assign wr_sync = chk_sync;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            delete_count <= '0;
        end else if (drop && delete_count != '1) begin
            delete_count <= delete_count + 1'b1;
        end
    end

endmodule

// File: block_fifo.sv
`timescale 1ns/1ps

module block_fifo #(
    parameter int addr_width = 4
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       wr,
    input  rate_adapt_pkg::block_payload_u             wr_payload,
    input  logic [rate_adapt_pkg::sync_hdr_width-1:0]  wr_sync,
    input  logic                                       rd,
    output rate_adapt_pkg::block_payload_u             rd_payload,
    output logic [rate_adapt_pkg::sync_hdr_width-1:0]  rd_sync,
    output logic                                       full,
    output logic                                       empty,
    output logic [addr_width:0]                        space
);
    import rate_adapt_pkg::*;

    localparam int depth = 2 ** addr_width;

    block_payload_u payload_mem [depth];
    logic [sync_hdr_width-1:0] sync_mem [depth];

    logic [addr_width-1:0] w_ptr;
    logic [addr_width-1:0] w_ptr_next;
    logic [addr_width-1:0] w_ptr_succ;
    logic [addr_width-1:0] r_ptr;
    logic [addr_width-1:0] r_ptr_next;
    logic [addr_width-1:0] r_ptr_succ;
    logic full_next;
    logic empty_next;
    logic [addr_width:0] space_next;
    logic wr_en;
    logic rd_en;

    assign wr_en = wr && !full;
    assign rd_en = rd && !empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            payload_mem[w_ptr] <= wr_payload;
            sync_mem[w_ptr] <= wr_sync;
        end
    end

    // A read that cannot be served hands back an idle block.
    assign rd_payload = rd_en ? payload_mem[r_ptr] : idle_payload;
    assign rd_sync = rd_en ? sync_mem[r_ptr] : sync_ctrl;

    always_comb begin
        w_ptr_succ = w_ptr + 1'b1;
        r_ptr_succ = r_ptr + 1'b1;
        w_ptr_next = w_ptr;
        r_ptr_next = r_ptr;
        full_next = full;
        empty_next = empty;
        space_next = space;
        case ({wr_en, rd_en})
            2'b10: begin
                w_ptr_next = w_ptr_succ;
                empty_next = 1'b0;
                full_next = (w_ptr_succ == r_ptr);
                space_next = space - 1'b1;
            end
            2'b01: begin
                r_ptr_next = r_ptr_succ;
                full_next = 1'b0;
                empty_next = (r_ptr_succ == w_ptr);
                space_next = space + 1'b1;
            end
            2'b11: begin
                w_ptr_next = w_ptr_succ;   // Fill level unchanged.
                r_ptr_next = r_ptr_succ;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w_ptr <= '0;
            r_ptr <= '0;
            full <= 1'b0;
            empty <= 1'b1;
            space <= (addr_width+1)'(depth);
        end else begin
            w_ptr <= w_ptr_next;
            r_ptr <= r_ptr_next;
            full <= full_next;
            empty <= empty_next;
            space <= space_next;
        end
    end

endmodule

// File: idle_inserter.sv
`timescale 1ns/1ps

module idle_inserter (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       out_ready,
    input  logic                                       empty,
    output logic                                       rd,
    input  rate_adapt_pkg::block_payload_u             rd_payload,
    input  logic [rate_adapt_pkg::sync_hdr_width-1:0]  rd_sync,
    output logic                                       out_valid,
    output rate_adapt_pkg::block_payload_u             out_payload,
    output logic [rate_adapt_pkg::sync_hdr_width-1:0]  out_sync,
    output logic [rate_adapt_pkg::count_width-1:0]     insert_count
);
    import rate_adapt_pkg::*;

    assign rd = out_ready && !empty;

    // Every request is answered on the next cycle, with an idle if the buffer is dry.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_payload <= idle_payload;
            out_sync <= sync_ctrl;
            insert_count <= '0;
        end else begin
            out_valid <= out_ready;
            if (out_ready) begin
                out_payload <= rd_payload;
                out_sync <= rd_sync;
            end
            if (out_ready && empty && insert_count != '1) begin
                insert_count <= insert_count + 1'b1;
            end
        end
    end

endmodule

// File: rate_adapt_top.sv
`timescale 1ns/1ps

module rate_adapt_top #(
    parameter int addr_width = 4,
    parameter int drop_level = 12
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       in_valid,
    input  rate_adapt_pkg::block_payload_u             in_payload,
    input  logic [rate_adapt_pkg::sync_hdr_width-1:0]  in_sync,
    output logic                                       in_ready,
    input  logic                                       out_ready,
    output logic                                       out_valid,
    output rate_adapt_pkg::block_payload_u             out_payload,
    output logic [rate_adapt_pkg::sync_hdr_width-1:0]  out_sync,
    output logic [rate_adapt_pkg::count_width-1:0]     error_count,
    output logic [rate_adapt_pkg::count_width-1:0]     delete_count,
    output logic [rate_adapt_pkg::count_width-1:0]     insert_count
);
    import rate_adapt_pkg::*;

    logic chk_valid;
    block_payload_u chk_payload;
    logic [sync_hdr_width-1:0] chk_sync;
    logic chk_is_idle;
    logic chk_ready;

    logic wr;
    block_payload_u wr_payload;
    logic [sync_hdr_width-1:0] wr_sync;
    logic rd;
    block_payload_u rd_payload;
    logic [sync_hdr_width-1:0] rd_sync;
    logic full;
    logic empty;
    logic [addr_width:0] space;

    block_check i_block_check (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_payload(in_payload),
        .in_sync(in_sync),
        .in_ready(in_ready),
        .chk_valid(chk_valid),
        .chk_payload(chk_payload),
        .chk_sync(chk_sync),
        .chk_is_idle(chk_is_idle),
        .chk_ready(chk_ready),
        .error_count(error_count)
    );

    idle_deleter #(
        .addr_width(addr_width),
        .drop_level(drop_level)
    ) i_idle_deleter (
        .clk(clk),
        .reset(reset),
        .chk_valid(chk_valid),
        .chk_payload(chk_payload),
        .chk_sync(chk_sync),
        .chk_is_idle(chk_is_idle),
        .chk_ready(chk_ready),
        .wr(wr),
        .wr_payload(wr_payload),
        .wr_sync(wr_sync),
        .full(full),
        .space(space),
        .delete_count(delete_count)
    );

    block_fifo #(
        .addr_width(addr_width)
    ) i_block_fifo (
        .clk(clk),
        .reset(reset),
        .wr(wr),
        .wr_payload(wr_payload),
        .wr_sync(wr_sync),
        .rd(rd),
        .rd_payload(rd_payload),
        .rd_sync(rd_sync),
        .full(full),
        .empty(empty),
        .space(space)
    );

    idle_inserter i_idle_inserter (
        .clk(clk),
        .reset(reset),
        .out_ready(out_ready),
        .empty(empty),
        .rd(rd),
        .rd_payload(rd_payload),
        .rd_sync(rd_sync),
        .out_valid(out_valid),
        .out_payload(out_payload),
        .out_sync(out_sync),
        .insert_count(insert_count)
    );

endmodule

// File: tb_rate_adapt.sv
`timescale 1ns/1ps

module tb_rate_adapt;
    import rate_adapt_pkg::*;

    localparam int addr_width = 4;
    localparam int drop_level = 12;
    localparam int depth = 2 ** addr_width;
    localparam int clk_period = 20;

    typedef struct packed {
        logic valid;
        logic [1:0] sync;
        logic [63:0] payload;
        logic out_ready;
        logic [3:0] delay;   // Idle input cycles after the block is taken.
    } stim_t;

    logic clk;
    logic reset;
    logic in_valid;
    block_payload_u in_payload;
    logic [sync_hdr_width-1:0] in_sync;
    logic in_ready;
    logic out_ready;
    logic out_valid;
    block_payload_u out_payload;
    logic [sync_hdr_width-1:0] out_sync;
    logic [count_width-1:0] error_count;
    logic [count_width-1:0] delete_count;
    logic [count_width-1:0] insert_count;

    stim_t table_q[$];
    bit table_ready = 1'b0;
    logic [31:0] lcg_state = 32'd63097;

    logic [65:0] model_q[$];   // Kept blocks as {sync, payload}.
    bit m_chk_valid;
    logic [65:0] m_chk_block;
    bit m_chk_idle;
    bit m_out_valid;
    logic [65:0] m_out_block;
    int m_errors;
    int m_deletes;
    int m_inserts;
    bit m_xfer;
    bit stall_seen;

    rate_adapt_top #(
        .addr_width(addr_width),
        .drop_level(drop_level)
    ) i_rate_adapt_top (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_payload(in_payload),
        .in_sync(in_sync),
        .in_ready(in_ready),
        .out_ready(out_ready),
        .out_valid(out_valid),
        .out_payload(out_payload),
        .out_sync(out_sync),
        .error_count(error_count),
        .delete_count(delete_count),
        .insert_count(insert_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [63:0] random_word();
        return {lcg_next(), lcg_next()};
    endfunction

    // Type 0x1e block with every character set to ch.
    function automatic block_payload_u make_ctrl_block(logic [6:0] ch);
        block_payload_u p;
        p.ctrl.block_type = block_type_ctrl_only;
        for (int i = 0; i < 8; i++) begin
            p.ctrl.chars[i] = ch;
        end
        return p;
    endfunction

    task automatic add_entry(input logic valid, input logic [1:0] sync,
                             input logic [63:0] payload, input logic rdy,
                             input logic [3:0] delay);
        stim_t s;
        s.valid = valid;
        s.sync = sync;
        s.payload = payload;
        s.out_ready = rdy;
        s.delay = delay;
        table_q.push_back(s);
    endtask

    task automatic build_table();
        block_payload_u p;
        logic [31:0] r;
        logic [1:0] sync;
        add_entry(1'b0, sync_data, '0, 1'b1, 4'd4);   // Empty buffer, idles inserted.
        for (int n = 0; n < 12; n++) begin
            r = lcg_next();
            p = random_word();
            sync = sync_ctrl;
            case (r[1:0])
                2'd0: sync = sync_data;
                2'd1: p.ctrl.block_type = 8'h78;
                2'd2: begin
                    p = make_ctrl_block(ctrl_idle);
                    p.ctrl.chars[3] = ctrl_error;   // Not an idle block.
                end
                default: p = make_ctrl_block(ctrl_idle);
            endcase
            add_entry(1'b1, sync, p, 1'b1, {2'b00, r[9:8]});
        end
        add_entry(1'b1, 2'b00, random_word(), 1'b1, 4'd0);
        add_entry(1'b1, sync_data, random_word(), 1'b1, 4'd0);
        add_entry(1'b1, 2'b11, random_word(), 1'b1, 4'd1);
        add_entry(1'b0, sync_data, '0, 1'b1, 4'd8);
        // Stop the reader, fill to the drop level, then to full.
        for (int n = 0; n < 12; n++) begin
            add_entry(1'b1, sync_data, random_word(), 1'b0, 4'd0);
        end
        for (int n = 0; n < 6; n++) begin
            add_entry(1'b1, sync_ctrl, make_ctrl_block(ctrl_idle), 1'b0, 4'd0);
        end
        for (int n = 0; n < 5; n++) begin
            add_entry(1'b1, sync_data, random_word(), 1'b0, 4'd0);
        end
        for (int n = 0; n < 6; n++) begin
            add_entry(1'b1, sync_data, random_word(), 1'b1, 4'd0);
        end
        add_entry(1'b0, sync_data, '0, 1'b1, 4'd15);
        for (int n = 0; n < 24; n++) begin
            r = lcg_next();
            p = random_word();
            sync = sync_data;
            if (r[2:0] == 3'd0) begin
                sync = r[3] ? 2'b11 : 2'b00;
            end else if (r[2:0] == 3'd1 || r[2:0] == 3'd2) begin
                sync = sync_ctrl;
                p = make_ctrl_block(ctrl_idle);
            end else if (r[2:0] == 3'd3) begin
                sync = sync_ctrl;
                p.ctrl.block_type = 8'h78;
            end
            add_entry(1'b1, sync, p, r[5:4] != 2'b00, {3'b000, r[6]});
        end
    endtask

    task automatic check_value(input string name, input logic [65:0] got,
                               input logic [65:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "simulation stopped at the first mismatch");
        end
    endtask

    // One clock edge of the reference model, from the inputs held over the edge.
    task automatic model_step();
        int fill;
        bit full;
        bit chk_xfer;
        bit drop;
        fill = model_q.size();
        full = (fill == depth);
        m_xfer = in_valid && (!m_chk_valid || !full);
        chk_xfer = m_chk_valid && !full;
        drop = chk_xfer && m_chk_idle && (fill >= drop_level);
        if (in_valid && !m_xfer) begin
            stall_seen = 1'b1;
        end
        m_out_valid = out_ready;
        if (out_ready) begin
            if (fill != 0) begin
                m_out_block = model_q.pop_front();
            end else begin
                m_out_block = {sync_ctrl, make_ctrl_block(ctrl_idle)};
                m_inserts++;
            end
        end
        if (chk_xfer && !drop) begin
            model_q.push_back(m_chk_block);
        end
        if (drop) begin
            m_deletes++;
        end
        if (m_xfer) begin
            m_chk_valid = 1'b1;
            if (in_sync == sync_data || in_sync == sync_ctrl) begin
                m_chk_block = {in_sync, in_payload};
                m_chk_idle = (in_sync == sync_ctrl) && (in_payload == make_ctrl_block(ctrl_idle));
            end else begin
                m_chk_block = {sync_ctrl, make_ctrl_block(ctrl_error)};
                m_chk_idle = 1'b0;
                m_errors++;
            end
        end else if (chk_xfer) begin
            m_chk_valid = 1'b0;
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        model_step();
        #1;
        check_value("out_valid", 66'(out_valid), 66'(m_out_valid));
        check_value("in_ready", 66'(in_ready), 66'(!m_chk_valid || model_q.size() != depth));
        check_value("error_count", 66'(error_count), 66'(m_errors));
        check_value("delete_count", 66'(delete_count), 66'(m_deletes));
        check_value("insert_count", 66'(insert_count), 66'(m_inserts));
        if (m_out_valid) begin
            check_value("out_sync", 66'(out_sync), 66'(m_out_block[65:64]));
            check_value("out_payload", 66'(out_payload), 66'(m_out_block[63:0]));
        end
        #1;
    endtask

    initial begin
        stim_t s;
        reset = 1'b1;
        in_valid = 1'b0;
        in_payload = '0;
        in_sync = sync_data;
        out_ready = 1'b0;
        m_chk_valid = 1'b0;
        m_chk_block = '0;
        m_chk_idle = 1'b0;
        m_out_valid = 1'b0;
        m_out_block = '0;
        m_errors = 0;
        m_deletes = 0;
        m_inserts = 0;
        stall_seen = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("out_valid", 66'(out_valid), 66'd0);
        check_value("in_ready", 66'(in_ready), 66'd1);
        check_value("error_count", 66'(error_count), 66'd0);
        check_value("delete_count", 66'(delete_count), 66'd0);
        check_value("insert_count", 66'(insert_count), 66'd0);
        foreach (table_q[i]) begin
            s = table_q[i];
            in_valid = s.valid;
            in_sync = s.sync;
            in_payload = s.payload;
            out_ready = s.out_ready;
            step_cycle();
            while (s.valid && !m_xfer) begin
                step_cycle();   // Held until in_ready takes it.
            end
            in_valid = 1'b0;
            repeat (s.delay) step_cycle();
        end
        out_ready = 1'b1;
        while (model_q.size() != 0 || m_chk_valid) begin
            step_cycle();
        end
        out_ready = 1'b0;
        repeat (2) step_cycle();
        if (m_errors > 0 && m_deletes > 0 && m_inserts > 0 && stall_seen) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("stimulus missed an error, deletion, insertion or input stall case");
            $display("Test failed");
            $fatal(1, "incomplete run of the rate adapter behaviors");
        end
    end

    initial begin
        wait (table_ready);
        #((table_q.size() * 10 + 200) * clk_period);
        $display("watchdog timeout, the run did not finish in the allowed time");
        $display("Test failed");
        $fatal(1, "simulation stopped by the watchdog");
    end

endmodule

// File: sim.f
rate_adapt_pkg.sv
block_check.sv
idle_deleter.sv
block_fifo.sv
idle_inserter.sv
rate_adapt_top.sv
tb_rate_adapt.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST ?= sim.f
TB_TOP ?= tb_rate_adapt
RTL_TOP ?= rate_adapt_top
BUILD_DIR ?= obj_dir
RTL_SRCS ?= rate_adapt_pkg.sv block_check.sv idle_deleter.sv block_fifo.sv \
            idle_inserter.sv rate_adapt_top.sv
LINT_FLAGS ?= --lint-only
SIM_FLAGS ?= --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
